/* Makefile */
FLIST = filelist.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module aes_core -f $(FLIST)

sim:
	verilator --binary --timing --assert --top-module tb_aes_core -f $(FLIST) --Mdir obj_dir
	./obj_dir/Vtb_aes_core > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Checks failed" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "All checks passed" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* filelist.f */
+incdir+sim
hdl/aes_field_pkg.sv
hdl/aes_cipher_pkg.sv
hdl/aes_sbox.sv
hdl/aes_key_expand.sv
hdl/aes_round_seq.sv
hdl/aes_round_mix.sv
hdl/aes_core.sv
sim/tb_aes_core.sv

/* hdl/aes_cipher_pkg.sv */
package aes_cipher_pkg;

	// ----------------------------------------------------------------------
	// AES-128 sizes
	// ----------------------------------------------------------------------
	localparam int AES_BLOCK_BYTES = 16;
	localparam int AES_NUM_ROUNDS = 10;

	// Rcon for round 1
	localparam aes_field_pkg::aes_byte_t AES_RCON_INIT = 8'h01;

	// byte 0 of the block sits in bits 127:120
	typedef logic [127:0] aes_block_t;

	// row 0 of the column sits in bits 31:24
	typedef logic [31:0] aes_col_t;

	// same 128 bits seen as bytes or as columns
	// bytes[15] and cols[3] hold byte 0 and column 0
	typedef union packed {
		aes_field_pkg::aes_byte_t [AES_BLOCK_BYTES-1:0] bytes;
		aes_col_t [3:0] cols;
	} aes_state_u;

	typedef logic [3:0] aes_round_t;

	typedef struct packed {
		logic load;
		logic advance;
		logic last;
	} aes_round_ctl_t;

endpackage

/* hdl/aes_core.sv */
`timescale 1ns/1ps

module aes_core (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_start,
	input  aes_cipher_pkg::aes_block_t i_key,
	input  aes_cipher_pkg::aes_block_t i_block,
	output aes_cipher_pkg::aes_block_t o_block,
	output logic o_done
);
	import aes_cipher_pkg::*;

	aes_round_ctl_t ctl;
	aes_state_u cur_state;
	aes_state_u sub_state;
	aes_state_u next_state;
	aes_state_u round_key;

	aes_round_seq u_seq (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_start(i_start),
		.i_block(i_block),
		.i_round_key(round_key),
		.i_next_state(next_state),
		.o_state(cur_state),
		.o_ctl(ctl),
		.o_block(o_block),
		.o_done(o_done)
	);

	// SubBytes, one S-box per state byte
	for (genvar i = 0; i < AES_BLOCK_BYTES; i++) begin : g_lane
		aes_sbox u_sbox (
			.i_byte(cur_state.bytes[i]),
			.o_byte(sub_state.bytes[i])
		);
	end

	aes_round_mix u_mix (
		.i_sub_state(sub_state),
		.i_round_key(round_key),
		.i_ctl(ctl),
		.o_next_state(next_state)
	);

	aes_key_expand u_key (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_key(i_key),
		.i_ctl(ctl),
		.o_round_key(round_key)
	);

endmodule

/* hdl/aes_field_pkg.sv */
package aes_field_pkg;

	// ----------------------------------------------------------------------
	// GF(2^8) element types
	// ----------------------------------------------------------------------
	typedef logic [7:0] aes_byte_t;

	// one half of a byte in the composite field GF((2^4)^2)
	typedef logic [3:0] aes_nibble_t;

	// x^8 = x^4 + x^3 + x + 1
	localparam aes_byte_t AES_POLY_REDUCE = 8'h1b;

	// constant added after the S-box affine matrix
	localparam aes_byte_t AES_AFFINE_CONST = 8'h63;

	// multiply by x, used by MixColumns and the round-constant step
	function automatic aes_byte_t aes_xtime(input aes_byte_t b);
		aes_byte_t shifted;
		shifted = {b[6:0], 1'b0};
		return b[7] ? (shifted ^ AES_POLY_REDUCE) : shifted;
	endfunction

endpackage

/* hdl/aes_key_expand.sv */
`timescale 1ns/1ps

module aes_key_expand (
	input  logic i_clk,
	input  logic i_rst,
	input  aes_cipher_pkg::aes_block_t i_key,
	input  aes_cipher_pkg::aes_round_ctl_t i_ctl,
	output aes_cipher_pkg::aes_state_u o_round_key
);
	import aes_field_pkg::*;
	import aes_cipher_pkg::*;

	aes_state_u key_q;
	aes_state_u next_key;
	aes_byte_t rcon_q;
	aes_col_t rot_word;
	aes_col_t sub_word;

	// RotWord of w3, the last column of the stored key
	assign rot_word = {key_q.cols[0][23:0], key_q.cols[0][31:24]};

	for (genvar i = 0; i < 4; i++) begin : g_sub_word
		aes_sbox u_sbox (
			.i_byte(rot_word[8*i +: 8]),
			.o_byte(sub_word[8*i +: 8])
		);
	end

	// word-wise xor chain from w0 down to w3
	always_comb begin
		next_key.cols[3] = key_q.cols[3] ^ sub_word ^ {rcon_q, 24'h000000};
		for (int i = 2; i >= 0; i--) begin
			next_key.cols[i] = key_q.cols[i] ^ next_key.cols[i + 1];
		end
	end

	// round 0 uses the cipher key as given
	assign o_round_key = i_ctl.load ? aes_state_u'(i_key) : next_key;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			rcon_q <= AES_RCON_INIT;
		end else if (i_ctl.load) begin
			rcon_q <= AES_RCON_INIT;
		end else if (i_ctl.advance) begin
			rcon_q <= aes_xtime(rcon_q);
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_ctl.load) begin
			key_q <= aes_state_u'(i_key);
		end else if (i_ctl.advance) begin
			key_q <= next_key;
		end
	end

	// a zero Rcon would mean the xtime step lost its reduction
	rcon_nonzero: assert property (@(posedge i_clk) disable iff (i_rst) rcon_q != '0);

endmodule

/* hdl/aes_round_mix.sv */
`timescale 1ns/1ps

module aes_round_mix (
	input  aes_cipher_pkg::aes_state_u i_sub_state,
	input  aes_cipher_pkg::aes_state_u i_round_key,
	input  aes_cipher_pkg::aes_round_ctl_t i_ctl,
	output aes_cipher_pkg::aes_state_u o_next_state
);
	import aes_field_pkg::*;
	import aes_cipher_pkg::*;

	aes_state_u shifted;

	// one column times the fixed 02 03 01 01 circulant
	function automatic aes_col_t mix_col(input aes_col_t c);
		aes_byte_t a0;
		aes_byte_t a1;
		aes_byte_t a2;
		aes_byte_t a3;
		a0 = c[31:24];
		a1 = c[23:16];
		a2 = c[15:8];
		a3 = c[7:0];
		return {aes_xtime(a0 ^ a1) ^ a1 ^ a2 ^ a3,
			aes_xtime(a1 ^ a2) ^ a2 ^ a3 ^ a0,
			aes_xtime(a2 ^ a3) ^ a3 ^ a0 ^ a1,
			aes_xtime(a3 ^ a0) ^ a0 ^ a1 ^ a2};
	endfunction

	// ShiftRows, row r moves left by r columns
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted.bytes[AES_BLOCK_BYTES - 1 - (4*c + r)] =
					i_sub_state.bytes[AES_BLOCK_BYTES - 1 - (4*((c + r) % 4) + r)];
			end
		end
	end

	// no MixColumns in the final round
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			o_next_state.cols[i] = (i_ctl.last ? shifted.cols[i] : mix_col(shifted.cols[i]))
				^ i_round_key.cols[i];
		end
	end

endmodule

/* hdl/aes_round_seq.sv */
`timescale 1ns/1ps

module aes_round_seq (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_start,
	input  aes_cipher_pkg::aes_block_t i_block,
	input  aes_cipher_pkg::aes_state_u i_round_key,
	input  aes_cipher_pkg::aes_state_u i_next_state,
	output aes_cipher_pkg::aes_state_u o_state,
	output aes_cipher_pkg::aes_round_ctl_t o_ctl,
	output aes_cipher_pkg::aes_block_t o_block,
	output logic o_done
);
	import aes_cipher_pkg::*;

	// zero while idle, else the round being computed
	aes_round_t round_q;
	// round 10 is in the state register, output goes out next edge
	logic fin_q;
	aes_state_u state_q;
	logic idle;

	assign idle = (round_q == '0);

	always_comb begin
		o_ctl.load = i_start & idle;
		o_ctl.advance = ~idle & ~fin_q;
		o_ctl.last = (round_q == aes_round_t'(AES_NUM_ROUNDS));
	end

	// ----------------------------------------------------------------------
	// round counter, output register and done strobe
	// ----------------------------------------------------------------------
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			round_q <= '0;
			fin_q <= 1'b0;
			o_block <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= fin_q;
			if (o_ctl.load) begin
				round_q <= aes_round_t'(1);
			end else if (fin_q) begin
				round_q <= '0;
				fin_q <= 1'b0;
				o_block <= aes_block_t'(state_q);
			end else if (o_ctl.advance) begin
				if (o_ctl.last) begin
					fin_q <= 1'b1;
				end else begin
					round_q <= round_q + 1'b1;
				end
			end
		end
	end

	// initial AddRoundKey on load, then one round per edge
	always_ff @(posedge i_clk) begin
		if (o_ctl.load) begin
			state_q <= aes_state_u'(i_block ^ i_round_key);
		end else if (o_ctl.advance) begin
			state_q <= i_next_state;
		end
	end

	assign o_state = state_q;

	round_in_range: assert property (@(posedge i_clk) disable iff (i_rst)
		round_q <= aes_round_t'(AES_NUM_ROUNDS));

	done_single: assert property (@(posedge i_clk) disable iff (i_rst) o_done |=> !o_done);

endmodule

/* hdl/aes_sbox.sv */
`timescale 1ns/1ps

module aes_sbox (
	input  aes_field_pkg::aes_byte_t i_byte,
	output aes_field_pkg::aes_byte_t o_byte
);
	import aes_field_pkg::*;

	aes_byte_t iso;
	aes_nibble_t sum;
	aes_nibble_t dinv;
	aes_byte_t inv;

	// ----------------------------------------------------------------------
	// GF(2^2) arithmetic
	// ----------------------------------------------------------------------
	function automatic logic [1:0] gf2_mul(input logic [1:0] a, input logic [1:0] b);
		return {(a[1] & b[1]) ^ (a[1] & b[0]) ^ (a[0] & b[1]),
			(a[1] & b[1]) ^ (a[0] & b[0])};
	endfunction

	// squaring, also the inverse in GF(2^2)
	function automatic logic [1:0] gf2_sq(input logic [1:0] a);
		return {a[1], a[1] ^ a[0]};
	endfunction

	function automatic logic [1:0] gf2_phi(input logic [1:0] a);
		return {a[1] ^ a[0], a[1]};
	endfunction

	// ----------------------------------------------------------------------
	// GF(2^4) arithmetic
	// ----------------------------------------------------------------------
	function automatic aes_nibble_t gf4_sq(input aes_nibble_t a);
		return {a[3], a[3] ^ a[2], a[2] ^ a[1], a[3] ^ a[1] ^ a[0]};
	endfunction

	function automatic aes_nibble_t gf4_lambda(input aes_nibble_t a);
		return {a[2] ^ a[0], a[3] ^ a[2] ^ a[1] ^ a[0], a[3], a[2]};
	endfunction

	function automatic aes_nibble_t gf4_mul(input aes_nibble_t a, input aes_nibble_t b);
		logic [1:0] hh;
		logic [1:0] mm;
		logic [1:0] ll;
		hh = gf2_mul(a[3:2], b[3:2]);
		mm = gf2_mul(a[3:2] ^ a[1:0], b[3:2] ^ b[1:0]);
		ll = gf2_mul(a[1:0], b[1:0]);
		return {ll ^ mm, ll ^ gf2_phi(hh)};
	endfunction

	function automatic aes_nibble_t gf4_inv(input aes_nibble_t a);
		logic [1:0] s;
		logic [1:0] d;
		logic [1:0] d_inv;
		s = a[3:2] ^ a[1:0];
		d = gf2_phi(gf2_sq(a[3:2])) ^ gf2_mul(s, a[1:0]);
		d_inv = gf2_sq(d);
		return {gf2_mul(a[3:2], d_inv), gf2_mul(s, d_inv)};
	endfunction

	// isomorphism GF(2^8) to GF((2^4)^2)
	function automatic aes_byte_t iso_map(input aes_byte_t a);
		return {a[7] ^ a[5],
			a[7] ^ a[6] ^ a[4] ^ a[3] ^ a[2] ^ a[1],
			a[7] ^ a[5] ^ a[3] ^ a[2],
			a[7] ^ a[5] ^ a[3] ^ a[2] ^ a[1],
			a[7] ^ a[6] ^ a[2] ^ a[1],
			a[7] ^ a[4] ^ a[3] ^ a[2] ^ a[1],
			a[6] ^ a[4] ^ a[1],
			a[6] ^ a[1] ^ a[0]};
	endfunction

	function automatic aes_byte_t iso_unmap(input aes_byte_t a);
		return {a[7] ^ a[6] ^ a[5] ^ a[1],
			a[6] ^ a[2],
			a[6] ^ a[5] ^ a[1],
			a[6] ^ a[5] ^ a[4] ^ a[2] ^ a[1],
			a[5] ^ a[4] ^ a[3] ^ a[2] ^ a[1],
			a[7] ^ a[4] ^ a[3] ^ a[2] ^ a[1],
			a[5] ^ a[4],
			a[6] ^ a[5] ^ a[4] ^ a[2] ^ a[0]};
	endfunction

	// affine matrix as a sum of left rotations
	function automatic aes_byte_t affine(input aes_byte_t a);
		return a ^ {a[6:0], a[7]} ^ {a[5:0], a[7:6]} ^ {a[4:0], a[7:5]}
			^ {a[3:0], a[7:4]} ^ AES_AFFINE_CONST;
	endfunction

	// high half times (high + low) over the norm, inverted in GF(2^4)
	assign iso = iso_map(i_byte);
	assign sum = iso[7:4] ^ iso[3:0];
	assign dinv = gf4_inv(gf4_lambda(gf4_sq(iso[7:4])) ^ gf4_mul(sum, iso[3:0]));
	assign inv = iso_unmap({gf4_mul(iso[7:4], dinv), gf4_mul(sum, dinv)});
	assign o_byte = affine(inv);

endmodule

/* sim/aes_ref.svh */
`ifndef AES_REF_SVH
`define AES_REF_SVH

// ----------------------------------------------------------------------
// AES-128 encryption model, plain GF(2^8) arithmetic on byte arrays
// ----------------------------------------------------------------------

// shift-and-add multiply modulo x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
	logic [7:0] p;
	logic [7:0] x;
	p = 8'h00;
	x = a;
	for (int i = 0; i < 8; i++) begin
		if (b[i]) begin
			p = p ^ x;
		end
		x = x[7] ? ({x[6:0], 1'b0} ^ 8'h1b) : {x[6:0], 1'b0};
	end
	return p;
endfunction

// inverse as a^254, zero maps to zero
function automatic logic [7:0] sub_byte(input logic [7:0] a);
	logic [7:0] inv;
	logic [7:0] pw;
	logic [7:0] s;
	inv = 8'h01;
	pw = a;
	for (int i = 0; i < 8; i++) begin
		if (i != 0) begin
			inv = gf_mul(inv, pw);
		end
		pw = gf_mul(pw, pw);
	end
	s = 8'h63;
	for (int i = 0; i < 8; i++) begin
		s[i] = s[i] ^ inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8]
			^ inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
	end
	return s;
endfunction

// byte i of a block sits at bits 127-8i down, column-major state
function automatic logic [127:0] encrypt_block(input logic [127:0] key, input logic [127:0] pt);
	logic [7:0] s [16];
	logic [7:0] t [16];
	logic [7:0] k [16];
	logic [7:0] g [4];
	logic [7:0] rcon;
	logic [127:0] ct;
	for (int i = 0; i < 16; i++) begin
		k[i] = key[127 - 8*i -: 8];
		s[i] = pt[127 - 8*i -: 8] ^ k[i];
	end
	rcon = 8'h01;
	for (int rnd = 1; rnd <= 10; rnd++) begin
		// next round key from the rotated last word
		g[0] = sub_byte(k[13]) ^ rcon;
		g[1] = sub_byte(k[14]);
		g[2] = sub_byte(k[15]);
		g[3] = sub_byte(k[12]);
		for (int i = 0; i < 16; i++) begin
			k[i] = k[i] ^ ((i < 4) ? g[i] : k[i - 4]);
		end
		rcon = gf_mul(rcon, 8'h02);
		// SubBytes with ShiftRows folded into the read index
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				t[4*c + r] = sub_byte(s[4*((c + r) % 4) + r]);
			end
		end
		for (int c = 0; c < 4; c++) begin
			if (rnd < 10) begin
				s[4*c + 0] = gf_mul(t[4*c], 8'h02) ^ gf_mul(t[4*c + 1], 8'h03)
					^ t[4*c + 2] ^ t[4*c + 3];
				s[4*c + 1] = t[4*c] ^ gf_mul(t[4*c + 1], 8'h02)
					^ gf_mul(t[4*c + 2], 8'h03) ^ t[4*c + 3];
				s[4*c + 2] = t[4*c] ^ t[4*c + 1] ^ gf_mul(t[4*c + 2], 8'h02)
					^ gf_mul(t[4*c + 3], 8'h03);
				s[4*c + 3] = gf_mul(t[4*c], 8'h03) ^ t[4*c + 1] ^ t[4*c + 2]
					^ gf_mul(t[4*c + 3], 8'h02);
			end else begin
				for (int r = 0; r < 4; r++) begin
					s[4*c + r] = t[4*c + r];
				end
			end
		end
		for (int i = 0; i < 16; i++) begin
			s[i] = s[i] ^ k[i];
		end
	end
	for (int i = 0; i < 16; i++) begin
		ct[127 - 8*i -: 8] = s[i];
	end
	return ct;
endfunction

`endif

/* sim/tb_aes_core.sv */
`timescale 1ns/1ps

module tb_aes_core;
	import aes_cipher_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_RANDOM = 40;
	// known vector, random blocks, the busy pair
	localparam int NUM_BLOCKS = 1 + NUM_RANDOM + 2;
	localparam int NUM_DONES = NUM_BLOCKS - 1;
	localparam int WATCHDOG_NS = (NUM_BLOCKS * 12 + 50) * CLK_PERIOD;
	localparam aes_block_t KNOWN_KEY = 128'h0f1571c947d9e8590cb7add6af7f6798;
	localparam aes_block_t KNOWN_PT = 128'h0123456789abcdeffedcba9876543210;
	localparam aes_block_t KNOWN_CT = 128'hff0b844a0853bf7c6934ab4364148fb9;

	logic i_clk;
	logic i_rst;
	logic i_start;
	aes_block_t i_key;
	aes_block_t i_block;
	aes_block_t o_block;
	logic o_done;

	logic [31:0] lcg_state;
	int block_errors;
	int flag_errors;
	int other_errors;
	int cycle;
	int done_at;
	int dones_seen;
	bit exp_done;
	aes_block_t exp_block;
	aes_block_t held_block;

	`include "aes_ref.svh"

	aes_core u_dut (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_start(i_start),
		.i_key(i_key),
		.i_block(i_block),
		.o_block(o_block),
		.o_done(o_done)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic aes_block_t rand_block();
		aes_block_t b;
		for (int i = 0; i < 4; i++) begin
			b[32*i +: 32] = lcg_next();
		end
		return b;
	endfunction

	task automatic check_block(input string name, input aes_block_t actual,
		input aes_block_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s expected %032h got %032h",
				$time, name, expected, actual);
			block_errors++;
		end
	endtask

	task automatic check_flag(input string name, input bit actual, input bit expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s expected %0b got %0b", $time, name, expected, actual);
			flag_errors++;
		end
	endtask

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	task automatic start_block(input aes_block_t key, input aes_block_t pt);
		i_key <= key;
		i_block <= pt;
		i_start <= 1'b1;
		@(posedge i_clk);
		i_start <= 1'b0;
	endtask

	// returns in the time step where o_done rises
	task automatic wait_done();
		@(posedge o_done);
	endtask

	// ----------------------------------------------------------------------
	// compare: idle/busy model of the start handshake
	// ----------------------------------------------------------------------
	always @(posedge i_clk) begin
		cycle = cycle + 1;
		if (!i_rst) begin
			exp_done = (cycle == done_at);
			check_flag("o_done", o_done, exp_done);
			if (o_done) begin
				dones_seen++;
			end
			if (exp_done) begin
				held_block = exp_block;
			end
			// o_block holds between done strobes
			check_block("o_block", o_block, held_block);
			if (i_start && cycle >= done_at) begin
				exp_block = encrypt_block(i_key, i_block);
				done_at = cycle + 12;
			end
		end
	end

	initial begin
		aes_block_t key;
		aes_block_t pt;
		i_clk = 1'b0;
		i_rst = 1'b1;
		i_start = 1'b0;
		i_key = '0;
		i_block = '0;
		lcg_state = 32'h4e786f17;
		block_errors = 0;
		flag_errors = 0;
		other_errors = 0;
		cycle = 0;
		done_at = 0;
		dones_seen = 0;
		held_block = '0;
		exp_block = '0;
		repeat (2) @(posedge i_clk);
		i_rst <= 1'b0;
		repeat (3) @(posedge i_clk);

		check_block("encrypt_block", encrypt_block(KNOWN_KEY, KNOWN_PT), KNOWN_CT);
		start_block(KNOWN_KEY, KNOWN_PT);
		wait_done();
		repeat (3) @(posedge i_clk);

		// each start lands in the done cycle of the block before
		for (int n = 0; n < NUM_RANDOM; n++) begin
			key = rand_block();
			pt = rand_block();
			start_block(key, pt);
			wait_done();
		end

		// second strobe while busy must be dropped
		key = rand_block();
		pt = rand_block();
		start_block(key, pt);
		repeat (3) @(posedge i_clk);
		key = rand_block();
		pt = rand_block();
		start_block(key, pt);
		wait_done();
		repeat (8) @(posedge i_clk);

		if (dones_seen != NUM_DONES) begin
			$display("wrong number of done strobes: saw %0d, wanted %0d", dones_seen, NUM_DONES);
			other_errors++;
		end
		$display("errors: block %0d, flag %0d, other %0d", block_errors, flag_errors, other_errors);
		if (block_errors + flag_errors + other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

endmodule
